/* Bender.yml */
package:
  name: egr_tx

sources:
  - source/egr_tx_pkg.sv
  - source/egr_port_queue.sv
  - source/egr_tdm_shim.sv
  - source/egr_tx_csr.sv
  - source/egr_tx_top.sv
  - target: test
    files:
      - verification/egr_tx_checker.sv
      - verification/egr_tx_tb.sv

/* project.f */
source/egr_tx_pkg.sv
source/egr_port_queue.sv
source/egr_tdm_shim.sv
source/egr_tx_csr.sv
source/egr_tx_top.sv
verification/egr_tx_checker.sv
verification/egr_tx_tb.sv

/* source/egr_port_queue.sv */
// Per port flit queue between the upstream writer and the TDM shim, head shown fall-through
`default_nettype none

module egr_port_queue #(
  parameter int QUEUE_DEPTH = 4                       // Power of two of at least 2
) (
  input  wire logic                 clk,
  input  wire logic                 reset_n,
  // Upstream write side
  input  wire logic                 wr_en,            // Dropped when full
  input  wire egr_tx_pkg::egr_flit_t wr_flit,
  // Shim read side
  input  wire logic                 buf_ren,          // Pop head at this edge
  output egr_tx_pkg::egr_flit_t     head_flit,        // Oldest entry
  output logic                      tc_rdy,           // Not empty
  output logic                      queue_full
);

  import egr_tx_pkg::*;

  localparam int PTR_W = $clog2(QUEUE_DEPTH);
  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

  egr_flit_t          mem [QUEUE_DEPTH];              // Flit storage
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [CNT_W-1:0]   count;                          // Occupancy
  logic               push;
  logic               pop;

  // ------------------------------------------------------------
  // Status and qualified strobes
  // ------------------------------------------------------------
  assign queue_full = (count == CNT_W'(QUEUE_DEPTH));
  assign tc_rdy     = (count != '0);
  assign push       = wr_en && !queue_full;           // Write to full queue is lost
  assign pop        = buf_ren && tc_rdy;              // Pop on empty ignored

  assign head_flit  = mem[rd_ptr];                    // FWFT head

  // Payload written at the tail
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= wr_flit;
    end
  end

  // Tail, head and occupancy
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Push with pop leaves the count as is
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule : egr_port_queue

`default_nettype wire

/* source/egr_tdm_shim.sv */
// TDM slot sequencer; pops the scheduled port queue and drives the EPL transmit bus
`default_nettype none

module egr_tdm_shim (
  input  wire logic                  clk,
  input  wire logic                  reset_n,
  // EPL request
  input  wire logic                  tx_enable,            // EPL ready for one word
  input  wire egr_tx_pkg::port_num_t tx_enable_port_num,   // Port the request is for
  // Configuration
  input  wire egr_tx_pkg::port_mode_e port_mode,           // From CSR block
  // Queue side
  input  wire logic [egr_tx_pkg::NUM_PORTS-1:0] tc_rdy,    // Queue not empty
  input  wire egr_tx_pkg::egr_flit_t head_flit [egr_tx_pkg::NUM_PORTS],
  output logic [egr_tx_pkg::NUM_PORTS-1:0]      buf_ren,   // Pop strobes
  // EPL transmit
  output logic                       tx_data_valid_resp,   // tx_enable delayed 2
  output egr_tx_pkg::port_num_t      tx_port_num,
  output egr_tx_pkg::egr_flit_t      tx_flit,
  // Status
  output logic                       port_num_err          // Wrong port requested
);

  import egr_tx_pkg::*;

  tdm_slot_e   state;                      // Current TDM slot
  tdm_slot_e   nx_state;
  port_mode_e  mode_q;                     // Registered port mode
  logic        tx_enable_d;                // Sampled request
  port_num_t   tx_enable_port_num_d;
  port_num_t   slot_port;                  // Port owning this slot
  logic        pop;                        // Scheduled port popped
  egr_flit_t   nx_tx_flit;

  // ------------------------------------------------------------
  // Slot sequencer
  // ------------------------------------------------------------

  // Steps every cycle whatever the mode
  always_comb begin
    case (state)
      SLOT0:   nx_state = SLOT1;
      SLOT1:   nx_state = SLOT2;
      SLOT2:   nx_state = SLOT3;
      SLOT3:   nx_state = SLOT0;
      default: nx_state = SLOT0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      state <= SLOT0;                      // First cycle after reset is slot 0
    end else begin
      state <= nx_state;
    end
  end

  // ------------------------------------------------------------
  // Request and mode sampling
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      tx_enable_d          <= 1'b0;
      tx_enable_port_num_d <= '0;
      tx_data_valid_resp   <= 1'b0;
      mode_q               <= MODE_1PORT;
    end else begin
      tx_enable_d          <= tx_enable;
      tx_enable_port_num_d <= tx_enable_port_num;
      tx_data_valid_resp   <= tx_enable_d;   // Credit back to EPL in E+2
      mode_q               <= port_mode;     // Mode change lands one cycle late
    end
  end

  // ------------------------------------------------------------
  // Port select and pop
  // ------------------------------------------------------------
  assign slot_port = sched_port(mode_q, state);

  // Pop only a matching request on a non-empty queue
  assign pop = tx_enable_d && (tx_enable_port_num_d == slot_port) && tc_rdy[slot_port];

  // Request for some other port
  assign port_num_err = tx_enable_d && (tx_enable_port_num_d != slot_port);

  always_comb begin
    buf_ren            = '0;
    buf_ren[slot_port] = pop;              // At most one strobe per cycle
  end

  // Idle word is all zeros
  assign nx_tx_flit = pop ? head_flit[slot_port] : '0;

  // ------------------------------------------------------------
  // Transmit registers
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      tx_port_num <= '0;
      tx_flit     <= '0;
    end else begin
      tx_port_num <= slot_port;            // Named port even when idle
      tx_flit     <= nx_tx_flit;
    end
  end

endmodule : egr_tdm_shim

`default_nettype wire

/* source/egr_tx_csr.sv */
// Port mode register and port number error status behind a simple strobe bus
`default_nettype none

module egr_tx_csr (
  input  wire logic       clk,
  input  wire logic       reset_n,
  // Register bus
  input  wire logic       cfg_we,                   // Write strobe
  input  wire logic [1:0] cfg_addr,
  input  wire logic [7:0] cfg_wdata,
  output logic [7:0]      cfg_rdata,                // Combinational read
  // Shim side
  input  wire logic       port_num_err,             // One cycle error pulse
  output egr_tx_pkg::port_mode_e port_mode
);

  import egr_tx_pkg::*;

  logic [7:0] err_count;                            // Saturates at 255
  logic       err_sticky;
  logic       wr_mode;
  logic       wr_clear;

  // ------------------------------------------------------------
  // Write decode
  // ------------------------------------------------------------
  assign wr_mode  = cfg_we && (cfg_addr == CSR_ADDR_MODE);
  assign wr_clear = cfg_we && (cfg_addr == CSR_ADDR_ERR_STICKY);  // Data ignored

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      port_mode <= MODE_1PORT;
    end else if (wr_mode) begin
      port_mode <= port_mode_e'(cfg_wdata[2:0]);    // Codes 5..7 are kept and act as one port
    end
  end

  // Error counter and flag
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      err_count  <= '0;
      err_sticky <= 1'b0;
    end else if (wr_clear) begin
      err_count  <= '0;                             // Clear wins over a same cycle pulse
      err_sticky <= 1'b0;
    end else if (port_num_err) begin
      err_sticky <= 1'b1;
      if (err_count != 8'hFF) begin
        err_count <= err_count + 8'd1;
      end
    end
  end

  // ------------------------------------------------------------
  // Read mux
  // ------------------------------------------------------------
  always_comb begin
    case (cfg_addr)
      CSR_ADDR_MODE:       cfg_rdata = {5'd0, port_mode};
      CSR_ADDR_ERR_COUNT:  cfg_rdata = err_count;
      CSR_ADDR_ERR_STICKY: cfg_rdata = {7'd0, err_sticky};
      default:             cfg_rdata = 8'd0;    // Unmapped
    endcase
  end

endmodule : egr_tx_csr

`default_nettype wire

/* source/egr_tx_pkg.sv */
// Shared types and constants for the egress transmit stage; imported by every RTL block
`default_nettype none

package egr_tx_pkg;

  // ------------------------------------------------------------
  // Sizes
  // ------------------------------------------------------------
  localparam int NUM_PORTS = 4;             // Logical ports in the group

  typedef logic [1:0] port_num_t;           // Logical port number

  // One transmit word toward the EPL
  typedef struct packed {
    logic [7:0][71:0] data_w_ecc;           // 8 lanes with ECC in [71:64]
    logic [7:0]       data_valid;           // Per lane valid mask
    logic [23:0]      metadata;             // SOP/EOP/TC info passed through
    logic [7:0]       ecc;                  // Covers data_valid and metadata
  } egr_flit_t;                             // 616 bits

  // ------------------------------------------------------------
  // TDM schedule
  // ------------------------------------------------------------
  typedef enum logic [2:0] {
    MODE_1PORT   = 3'd0,                    // 0,0,0,0
    MODE_2PORT   = 3'd1,                    // 0,2,0,2
    MODE_4PORT   = 3'd2,                    // 0,1,2,3
    MODE_3PORT_A = 3'd3,                    // 0,2,1,2
    MODE_3PORT_B = 3'd4                     // 0,2,0,3
  } port_mode_e;                            // Codes 5..7 act as one port

  typedef enum logic [1:0] {
    SLOT0 = 2'd0,
    SLOT1 = 2'd1,
    SLOT2 = 2'd2,
    SLOT3 = 2'd3
  } tdm_slot_e;

  // Port owning a slot under a given mode
  function automatic port_num_t sched_port(port_mode_e mode, tdm_slot_e slot);
    port_num_t port;
    port = 2'd0;                            // One port mode and reserved codes
    case (mode)
      MODE_2PORT:   port = slot[0] ? 2'd2 : 2'd0;
      MODE_4PORT:   port = port_num_t'(slot);
      MODE_3PORT_A: port = (slot == SLOT2) ? 2'd1 : (slot[0] ? 2'd2 : 2'd0);
      MODE_3PORT_B: port = (slot == SLOT1) ? 2'd2 : ((slot == SLOT3) ? 2'd3 : 2'd0);
      default:      port = 2'd0;
    endcase
    return port;
  endfunction

  // ------------------------------------------------------------
  // CSR map
  // ------------------------------------------------------------
  localparam logic [1:0] CSR_ADDR_MODE       = 2'd0;  // RW port mode in [2:0]
  localparam logic [1:0] CSR_ADDR_ERR_COUNT  = 2'd1;  // RO saturating error count
  localparam logic [1:0] CSR_ADDR_ERR_STICKY = 2'd2;  // Sticky flag cleared by any write

endpackage : egr_tx_pkg

`default_nettype wire

/* source/egr_tx_top.sv */
// Egress transmit stage top; four port queues feeding the TDM shim, plus the CSR block
`default_nettype none

module egr_tx_top #(
  parameter int QUEUE_DEPTH = 4                             // Entries per port queue
) (
  input  wire logic                  clk,
  input  wire logic                  reset_n,
  // Upstream writers
  input  wire logic [egr_tx_pkg::NUM_PORTS-1:0] wr_en,
  input  wire egr_tx_pkg::egr_flit_t wr_flit [egr_tx_pkg::NUM_PORTS],
  output logic [egr_tx_pkg::NUM_PORTS-1:0]      queue_full,
  // EPL transmit channel
  input  wire logic                  tx_enable,
  input  wire egr_tx_pkg::port_num_t tx_enable_port_num,
  output logic                       tx_data_valid_resp,
  output egr_tx_pkg::port_num_t      tx_port_num,
  output egr_tx_pkg::egr_flit_t      tx_flit,
  // Register bus
  input  wire logic                  cfg_we,
  input  wire logic [1:0]            cfg_addr,
  input  wire logic [7:0]            cfg_wdata,
  output logic [7:0]                 cfg_rdata
);

  import egr_tx_pkg::*;

  egr_flit_t             head_flit [NUM_PORTS];             // Queue heads to shim
  logic [NUM_PORTS-1:0]  tc_rdy;
  logic [NUM_PORTS-1:0]  buf_ren;
  port_mode_e            port_mode;                         // CSR to shim
  logic                  port_num_err;                      // Shim to CSR

  // ------------------------------------------------------------
  // Per port queues
  // ------------------------------------------------------------
  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_queue
    egr_port_queue #(
      .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_egr_port_queue (
      .clk        (clk),
      .reset_n    (reset_n),
      .wr_en      (wr_en[p]),
      .wr_flit    (wr_flit[p]),
      .buf_ren    (buf_ren[p]),
      .head_flit  (head_flit[p]),
      .tc_rdy     (tc_rdy[p]),
      .queue_full (queue_full[p])
    );
  end

  // TDM mux onto the EPL channel
  egr_tdm_shim u_egr_tdm_shim (
    .clk                (clk),
    .reset_n            (reset_n),
    .tx_enable          (tx_enable),
    .tx_enable_port_num (tx_enable_port_num),
    .port_mode          (port_mode),
    .tc_rdy             (tc_rdy),
    .head_flit          (head_flit),
    .buf_ren            (buf_ren),
    .tx_data_valid_resp (tx_data_valid_resp),
    .tx_port_num        (tx_port_num),
    .tx_flit            (tx_flit),
    .port_num_err       (port_num_err)
  );

  egr_tx_csr u_egr_tx_csr (
    .clk          (clk),
    .reset_n      (reset_n),
    .cfg_we       (cfg_we),
    .cfg_addr     (cfg_addr),
    .cfg_wdata    (cfg_wdata),
    .cfg_rdata    (cfg_rdata),
    .port_num_err (port_num_err),
    .port_mode    (port_mode)
  );

endmodule : egr_tx_top

`default_nettype wire

/* verification/egr_tx_checker.sv */
// Scoreboard beside the DUT; models queues, schedule and CSRs and compares every cycle
`default_nettype none

module egr_tx_checker #(
  parameter int QUEUE_DEPTH = 4
) (
  input  wire logic                              clk,
  input  wire logic                              reset_n,
  input  wire logic [egr_tx_pkg::NUM_PORTS-1:0]  wr_en,
  input  wire egr_tx_pkg::egr_flit_t             wr_flit [egr_tx_pkg::NUM_PORTS],
  input  wire logic [egr_tx_pkg::NUM_PORTS-1:0]  queue_full,
  input  wire logic                              tx_enable,
  input  wire egr_tx_pkg::port_num_t             tx_enable_port_num,
  input  wire logic                              tx_data_valid_resp,
  input  wire egr_tx_pkg::port_num_t             tx_port_num,
  input  wire egr_tx_pkg::egr_flit_t             tx_flit,
  input  wire logic                              cfg_we,
  input  wire logic [1:0]                        cfg_addr,
  input  wire logic [7:0]                        cfg_wdata,
  input  wire logic [7:0]                        cfg_rdata,
  output int                                     error_count,
  output int                                     check_count
);

  import egr_tx_pkg::*;

  egr_flit_t  model_mem [NUM_PORTS][QUEUE_DEPTH];  // Index 0 is the head
  int         model_size [NUM_PORTS];
  int         pre_size [NUM_PORTS];
  logic [1:0] model_slot;
  logic [2:0] model_csr_mode;
  logic [2:0] model_mode_q;                // Mode as seen by the shim
  logic       req_en;                      // Request sampled last edge
  port_num_t  req_port;
  logic       exp_resp;
  port_num_t  exp_port;
  egr_flit_t  exp_flit;
  port_num_t  owner;
  logic       popped;
  logic       err_now;
  logic [7:0] model_err_count;
  logic       model_sticky;
  logic [7:0] exp_rdata;
  logic       armed = 1'b0;
  int         errors = 0;
  int         checks = 0;

  assign error_count = errors;
  assign check_count = checks;

  // Slot map per mode with two bits per slot
  function automatic port_num_t scheduled_port(logic [2:0] mode, logic [1:0] slot);
    logic [7:0] map;
    case (mode)
      3'd1:    map = 8'h88;                // 0 2 0 2
      3'd2:    map = 8'hE4;                // 0 1 2 3
      3'd3:    map = 8'h98;                // 0 2 1 2
      3'd4:    map = 8'hC8;                // 0 2 0 3
      default: map = 8'h00;
    endcase
    return map[slot*2 +: 2];
  endfunction

  task automatic expect_true(input logic ok, input string what);
    checks++;
    if (ok !== 1'b1) begin
      errors++;
      $display("[FAIL] %0t %s", $time, what);
    end
  endtask

  always @(posedge clk) begin
    // Compare what the previous edge produced
    if (armed) begin
      expect_true(tx_data_valid_resp === exp_resp,
        $sformatf("tx_data_valid_resp is %b, expected %b", tx_data_valid_resp, exp_resp));
      expect_true(tx_port_num === exp_port,
        $sformatf("tx_port_num is %0d, expected %0d", tx_port_num, exp_port));
      expect_true(tx_flit === exp_flit, $sformatf("tx_flit differs on port %0d", exp_port));
      for (int p = 0; p < NUM_PORTS; p++) begin
        expect_true(queue_full[p] === (model_size[p] == QUEUE_DEPTH),
          $sformatf("queue_full[%0d] is %b with %0d entries", p, queue_full[p], model_size[p]));
      end
      case (cfg_addr)
        CSR_ADDR_MODE:       exp_rdata = {5'd0, model_csr_mode};
        CSR_ADDR_ERR_COUNT:  exp_rdata = model_err_count;
        CSR_ADDR_ERR_STICKY: exp_rdata = {7'd0, model_sticky};
        default:             exp_rdata = 8'd0;
      endcase
      expect_true(cfg_rdata === exp_rdata, $sformatf("CSR %0d reads %0d, expected %0d",
        cfg_addr, cfg_rdata, exp_rdata));
    end
    if (!reset_n) begin
      armed           = 1'b1;
      for (int p = 0; p < NUM_PORTS; p++) model_size[p] = 0;
      model_slot      = 2'd0;
      model_csr_mode  = 3'd0;
      model_mode_q    = 3'd0;
      req_en          = 1'b0;
      req_port        = '0;
      exp_resp        = 1'b0;
      exp_port        = '0;
      exp_flit        = '0;
      model_err_count = 8'd0;
      model_sticky    = 1'b0;
    end else begin
      owner    = scheduled_port(model_mode_q, model_slot);
      popped   = req_en && (req_port == owner) && (model_size[owner] != 0);
      err_now  = req_en && (req_port != owner);
      exp_flit = popped ? model_mem[owner][0] : '0;
      exp_port = owner;
      exp_resp = req_en;
      for (int p = 0; p < NUM_PORTS; p++) pre_size[p] = model_size[p];
      if (popped) begin
        for (int i = 0; i < QUEUE_DEPTH - 1; i++) model_mem[owner][i] = model_mem[owner][i+1];
        model_size[owner]--;
      end
      // Fullness before the edge decides a write
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (wr_en[p] && pre_size[p] < QUEUE_DEPTH) begin
          model_mem[p][model_size[p]] = wr_flit[p];
          model_size[p]++;
        end
      end
      if (cfg_we && cfg_addr == CSR_ADDR_ERR_STICKY) begin
        model_err_count = 8'd0;            // Clear beats a pulse
        model_sticky    = 1'b0;
      end else if (err_now) begin
        model_sticky = 1'b1;
        if (model_err_count != 8'hFF) model_err_count++;
      end
      model_mode_q = model_csr_mode;       // One cycle behind the register
      if (cfg_we && cfg_addr == CSR_ADDR_MODE) model_csr_mode = cfg_wdata[2:0];
      req_en     = tx_enable;
      req_port   = tx_enable_port_num;
      model_slot = model_slot + 2'd1;
    end
  end

endmodule : egr_tx_checker

`default_nettype wire

/* verification/egr_tx_tb.sv */
// Testbench top for the egress transmit stage; drives random traffic through all five modes
`default_nettype none

module egr_tx_tb;

  import egr_tx_pkg::*;

  localparam int          QUEUE_DEPTH     = 4;
  localparam int          CYCLES_PER_MODE = 400;
  localparam int          TIMEOUT_CYCLES  = 5 * CYCLES_PER_MODE + 200;  // Runs plus setup
  localparam logic [31:0] SEED            = 32'd96649;

  logic                 clk;
  logic                 reset_n;
  logic [NUM_PORTS-1:0] wr_en;
  egr_flit_t            wr_flit [NUM_PORTS];
  logic [NUM_PORTS-1:0] queue_full;
  logic                 tx_enable;
  port_num_t            tx_enable_port_num;
  logic                 tx_data_valid_resp;
  port_num_t            tx_port_num;
  egr_flit_t            tx_flit;
  logic                 cfg_we;
  logic [1:0]           cfg_addr;
  logic [7:0]           cfg_wdata;
  logic [7:0]           cfg_rdata;
  int                   error_count;
  int                   check_count;

  logic [31:0] rng;                         // xorshift state
  logic [1:0]  tb_slot;                     // DUT slot during the current cycle
  port_mode_e  cur_mode;
  int          occ [NUM_PORTS];             // Upper bound on queue occupancy
  int          cycle_count;

  egr_tx_top #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_egr_tx_top (.*);

  egr_tx_checker #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_egr_tx_checker (.*);

  initial clk = 1'b0;
  always #10 clk = ~clk;

  // Slot count since reset stepping like the schedule
  always @(posedge clk) begin
    if (!reset_n) tb_slot <= 2'd0;
    else          tb_slot <= tb_slot + 2'd1;
  end

  // ------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------
  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic port_num_t slot_owner(port_mode_e mode, logic [1:0] slot);
    case (mode)
      MODE_2PORT:   return slot[0] ? 2'd2 : 2'd0;
      MODE_4PORT:   return slot;
      MODE_3PORT_A: return (slot == 2'd2) ? 2'd1 : (slot[0] ? 2'd2 : 2'd0);
      MODE_3PORT_B: return (slot == 2'd1) ? 2'd2 : ((slot == 2'd3) ? 2'd3 : 2'd0);
      default:      return 2'd0;            // One port and reserved codes
    endcase
  endfunction

  function automatic egr_flit_t random_flit();
    logic [639:0] bits;
    egr_flit_t    flit;
    for (int w = 0; w < 20; w++) bits[w*32 +: 32] = next_rand();
    flit = bits[$bits(egr_flit_t)-1:0];
    flit.data_valid[0] = 1'b1;              // Never equal to the idle word
    return flit;
  endfunction

  // Wait one edge, retire observed pops, then step to the drive point
  task automatic next_cycle();
    @(posedge clk);
    if (tx_flit != '0 && occ[tx_port_num] > 0) occ[tx_port_num]--;
    #2;
  endtask

  task automatic drive_idle();
    wr_en     = '0;
    tx_enable = 1'b0;
    cfg_we    = 1'b0;
  endtask

  task automatic drive_writes(input int pct, input bit force_all);
    logic [31:0] r;
    for (int p = 0; p < NUM_PORTS; p++) begin
      r = next_rand();
      wr_en[p] = force_all || ((r % 100) < pct && occ[p] < QUEUE_DEPTH);
      if (wr_en[p]) begin
        wr_flit[p] = random_flit();
        if (occ[p] < QUEUE_DEPTH) occ[p]++;   // Writes beyond full are dropped
      end
    end
  endtask

  task automatic drive_request();
    logic [31:0] r;
    r = next_rand();
    tx_enable = (r % 100) < 70;
    r = next_rand();
    if (r[2:0] == 3'd0) tx_enable_port_num = r[9:8];          // Stray port about 1 in 8
    else tx_enable_port_num = slot_owner(cur_mode, tb_slot + 2'd1);
  endtask

  task automatic csr_write(input logic [1:0] addr, input logic [7:0] data);
    cfg_we    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
    next_cycle();
    cfg_we    = 1'b0;
    cfg_addr  = CSR_ADDR_MODE;
    cfg_wdata = 8'd0;
  endtask

  // Hold a read address for one cycle
  task automatic csr_look(input logic [1:0] addr);
    cfg_addr = addr;
    next_cycle();
    cfg_addr = CSR_ADDR_MODE;
  endtask

  task automatic run_mode(input port_mode_e mode);
    drive_idle();
    repeat (3) next_cycle();                // Let the pipeline empty
    csr_write(CSR_ADDR_MODE, {5'd0, mode});
    cur_mode = mode;
    next_cycle();                           // Shim copy of the mode
    while (tb_slot != 2'd0) next_cycle();
    repeat (CYCLES_PER_MODE) begin
      drive_writes(40, 1'b0);
      drive_request();
      next_cycle();
    end
    drive_idle();
    repeat (3) next_cycle();
    csr_look(CSR_ADDR_ERR_COUNT);
    csr_look(CSR_ADDR_ERR_STICKY);
    csr_write(CSR_ADDR_ERR_STICKY, 8'hA5);  // Any value clears
    csr_look(CSR_ADDR_ERR_COUNT);
    csr_look(CSR_ADDR_ERR_STICKY);
  endtask

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------
  initial begin
    rng                = SEED;
    reset_n            = 1'b0;
    wr_en              = '0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      wr_flit[p] = '0;
      occ[p]     = 0;
    end
    tx_enable          = 1'b0;
    tx_enable_port_num = '0;
    cfg_we             = 1'b0;
    cfg_addr           = CSR_ADDR_MODE;
    cfg_wdata          = 8'd0;
    cur_mode           = MODE_1PORT;
    repeat (2) @(posedge clk);
    #2 reset_n = 1'b1;
    // Overfill every queue with no requests
    repeat (QUEUE_DEPTH + 3) begin
      drive_writes(100, 1'b1);
      next_cycle();
    end
    drive_idle();
    next_cycle();
    for (int m = 0; m < 5; m++) run_mode(port_mode_e'(m));
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: test did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("TESTS FAILED");
    $finish;
  end

endmodule : egr_tx_tb

`default_nettype wire
